// File: Bender.yml
package:
  name: aes_encrypt

sources:
  - include_dirs:
      - include
    files:
      - hw/AESDefinitions.sv
      - hw/ExpandKey.sv
      - hw/CipherRound.sv
      - hw/AESEncoder.sv
      - hw/AESEncryptTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/AESEncrypt_properties.sv
      - verif/AESEncryptTb.sv

// File: files.f
+incdir+include
hw/AESDefinitions.sv
hw/ExpandKey.sv
hw/CipherRound.sv
hw/AESEncoder.sv
hw/AESEncryptTop.sv
verif/AESEncrypt_properties.sv
verif/AESEncryptTb.sv

// File: hw/AESDefinitions.sv
// AES shared types
// byte, block, key and round-key types plus the forward S-box table

`include "aes_cfg.svh"

package AESDefinitions;

    // bytes in one cipher block
    localparam int AES_STATE_SIZE = 16;

    typedef logic [7:0] byte_t;

    // column-major block, byte 0 is row 0 of column 0
    typedef byte_t [0:AES_STATE_SIZE-1] block_t;
    typedef byte_t [0:AES_STATE_SIZE-1] roundKey_t;

    typedef byte_t [0:`AES_KEY_BYTES-1] aesKey_t;

    // index 0 is the whitening key applied before the first round
    typedef roundKey_t [0:`AES_NUM_ROUNDS] roundKeys_t;

    typedef struct packed {
        aesKey_t key;
        block_t  plaintext;
    } aesReq_t;

    // forward substitution table, indexed directly by the input byte
    localparam byte_t sbox [0:255] = '{
        8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
        8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
        8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
        8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
        8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
        8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
        8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
        8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
        8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
        8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
        8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
        8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
        8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
        8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
        8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
        8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
        8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
        8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
        8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
        8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
        8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
        8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
        8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
        8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
        8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
        8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
        8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
        8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
        8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
        8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
        8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
        8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
    };

endpackage

// File: hw/AESEncoder.sv
// AES iterative encoder
// steps one block through the whitening step and all cipher rounds, one per clock

`include "aes_cfg.svh"

module AESEncoder
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  AESDefinitions::block_t     plaintext,
    input  AESDefinitions::roundKeys_t roundKeys,
    output logic                       busy,
    output logic                       done,
    output AESDefinitions::block_t     ciphertext
);

    localparam int NUM_ROUNDS = `AES_NUM_ROUNDS;
    localparam int CNT_W = $clog2(NUM_ROUNDS + 1);

    AESDefinitions::block_t    stateReg;
    AESDefinitions::block_t    roundOut;
    AESDefinitions::roundKey_t curKey;
    logic [CNT_W-1:0]          roundCnt;
    logic                      firstRound;
    logic                      lastRound;
    logic                      accept;

    // a start pulse only counts while the encoder is idle
    assign accept = start && !busy;

    assign curKey = roundKeys[roundCnt];
    assign firstRound = (roundCnt == '0);
    assign lastRound = (roundCnt == CNT_W'(NUM_ROUNDS));

    CipherRound round
    (
        .state      (stateReg),
        .roundKey   (curKey),
        .firstRound (firstRound),
        .lastRound  (lastRound),
        .nextState  (roundOut)
    );

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy <= 1'b0;
            done <= 1'b0;
            roundCnt <= '0;
            ciphertext <= '0;
        end
        else
        begin
            done <= 1'b0;
            if (accept)
            begin
                busy <= 1'b1;
                roundCnt <= '0;
            end
            else if (busy && lastRound)
            begin
                // final round result goes straight out, the state register is not reused
                busy <= 1'b0;
                done <= 1'b1;
                ciphertext <= roundOut;
            end
            else if (busy)
            begin
                roundCnt <= roundCnt + CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            stateReg <= plaintext;
        else if (busy)
            stateReg <= roundOut;
    end

endmodule

// File: hw/AESEncryptTop.sv
// AES encryptor top level
// holds the request key and ties the key schedule to the iterative encoder

`include "aes_cfg.svh"

module AESEncryptTop
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  AESDefinitions::aesReq_t req,
    output logic                    busy,
    output logic                    done,
    output AESDefinitions::block_t  ciphertext
);

    AESDefinitions::aesKey_t    keyReg;
    AESDefinitions::roundKeys_t roundKeys;

    // the key stays put for the whole block so the schedule never changes mid-run
    always_ff @(posedge clk)
    begin
        if (start && !busy)
            keyReg <= req.key;
    end

    ExpandKey #(
        .KEY_SIZE    (`AES_KEY_SIZE),
        .NUM_ROUNDS  (`AES_NUM_ROUNDS),
        .KEY_BYTES   (`AES_KEY_BYTES),
        .roundKeys_t (AESDefinitions::roundKeys_t),
        .key_t       (AESDefinitions::aesKey_t)
    ) keyExpansion
    (
        .key       (keyReg),
        .roundKeys (roundKeys)
    );

    AESEncoder encoder
    (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .plaintext  (req.plaintext),
        .roundKeys  (roundKeys),
        .busy       (busy),
        .done       (done),
        .ciphertext (ciphertext)
    );

endmodule

// File: hw/CipherRound.sv
// AES encryption round
// SubBytes, ShiftRows, MixColumns and AddRoundKey on one 128-bit state

module CipherRound
(
    input  AESDefinitions::block_t    state,
    input  AESDefinitions::roundKey_t roundKey,
    input  logic                      firstRound,
    input  logic                      lastRound,
    output AESDefinitions::block_t    nextState
);

    typedef AESDefinitions::byte_t [0:3] column_t;

    AESDefinitions::block_t subbed;
    AESDefinitions::block_t shifted;
    AESDefinitions::block_t mixed;

    // multiply by x in GF(2^8) modulo the AES polynomial
    function automatic AESDefinitions::byte_t xtime(input AESDefinitions::byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic column_t mixColumn(input column_t a);
        column_t m;
        m[0] = xtime(a[0]) ^ xtime(a[1]) ^ a[1] ^ a[2] ^ a[3];
        m[1] = a[0] ^ xtime(a[1]) ^ xtime(a[2]) ^ a[2] ^ a[3];
        m[2] = a[0] ^ a[1] ^ xtime(a[2]) ^ xtime(a[3]) ^ a[3];
        m[3] = xtime(a[0]) ^ a[0] ^ a[1] ^ a[2] ^ xtime(a[3]);
        return m;
    endfunction

    always_comb
    begin
        for (int i = 0; i < AESDefinitions::AES_STATE_SIZE; i++)
        begin
            subbed[i] = AESDefinitions::sbox[state[i]];
        end
    end

    // row r rotates left by r columns; byte index is column * 4 + row
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                shifted[c*4 + r] = subbed[((c + r) % 4)*4 + r];
            end
        end
    end

    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            mixed[c*4 +: 4] = mixColumn(shifted[c*4 +: 4]);
        end
    end

    always_comb
    begin
        if (firstRound)
            nextState = state ^ AESDefinitions::block_t'(roundKey);
        else if (lastRound)
            nextState = shifted ^ AESDefinitions::block_t'(roundKey);
        else
            nextState = mixed ^ AESDefinitions::block_t'(roundKey);
    end

endmodule

// File: hw/ExpandKey.sv
// AES key schedule
// combinational expansion of a 128-, 192- or 256-bit key into all round keys

module ExpandKey #(
    parameter int KEY_SIZE = 128,
    parameter int NUM_ROUNDS = 10,
    parameter int KEY_BYTES = KEY_SIZE / 8,
    parameter type roundKeys_t = AESDefinitions::roundKey_t [0:NUM_ROUNDS],
    parameter type key_t = AESDefinitions::byte_t [0:KEY_BYTES-1]
)
(
    input  key_t       key,
    output roundKeys_t roundKeys
);

    localparam int COL_BYTES = 4;
    localparam int KEY_NUM_COLS = KEY_BYTES / COL_BYTES;
    localparam int ROUND_KEY_BITS = AESDefinitions::AES_STATE_SIZE * 8;
    localparam int ROUND_KEYS_BITS = ROUND_KEY_BITS * (NUM_ROUNDS + 1);

    // number of key-sized blocks grown after the original key
    localparam int NUM_EXP_BLOCKS = (KEY_SIZE == 256) ? 7 : (KEY_SIZE == 192) ? 8 : 10;
    localparam int SCHED_BITS = KEY_SIZE * (NUM_EXP_BLOCKS + 1);

    // the last block overshoots the needed words for 192 and 256 bit keys,
    // the surplus sits at the low end and is shifted out
    localparam int KEY_SCH_SHIFT = SCHED_BITS - ROUND_KEYS_BITS;

    // entry 0 is never used, block j takes RCON[j]
    localparam AESDefinitions::byte_t RCON [0:10] = '{
        8'h8d, 8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
        8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

    typedef AESDefinitions::byte_t [0:COL_BYTES-1] keyWord_t;
    typedef keyWord_t [0:KEY_NUM_COLS-1] keyBlock_t;

    keyBlock_t [0:NUM_EXP_BLOCKS] keyBlocks;
    logic [SCHED_BITS-1:0] schedShifted;

    function automatic keyWord_t rotWord(input keyWord_t w);
        return {w[1:COL_BYTES-1], w[0]};
    endfunction

    function automatic keyWord_t subWord(input keyWord_t w);
        keyWord_t s;
        for (int i = 0; i < COL_BYTES; i++)
        begin
            s[i] = AESDefinitions::sbox[w[i]];
        end
        return s;
    endfunction

    function automatic keyWord_t applyRcon(input int blk, input keyWord_t w);
        keyWord_t r;
        r = w;
        r[0] = w[0] ^ RCON[blk];
        return r;
    endfunction

    function automatic keyBlock_t expandBlock(input int blk, input keyBlock_t prev);
        keyBlock_t next;
        next[0] = prev[0] ^ applyRcon(blk, subWord(rotWord(prev[KEY_NUM_COLS-1])));
        for (int i = 1; i < KEY_NUM_COLS; i++)
        begin
            // 256-bit keys pass the middle word through the S-box once more
            if (KEY_SIZE == 256 && i == 4)
                next[i] = subWord(next[i-1]) ^ prev[i];
            else
                next[i] = next[i-1] ^ prev[i];
        end
        return next;
    endfunction

    always_comb
    begin
        keyBlocks[0] = keyBlock_t'(key);
        for (int j = 1; j <= NUM_EXP_BLOCKS; j++)
        begin
            keyBlocks[j] = expandBlock(j, keyBlocks[j-1]);
        end
    end

    // block 0 sits in the upper bits, so the round keys are the top of the schedule
    assign schedShifted = keyBlocks >> KEY_SCH_SHIFT;
    assign roundKeys = roundKeys_t'(schedShifted[ROUND_KEYS_BITS-1:0]);

endmodule

// File: include/aes_cfg.svh
// AES build configuration
// picks the key size; the round count and key byte count follow from it

`ifndef AES_CFG_SVH
`define AES_CFG_SVH

// key width in bits, one of 128, 192 or 256
`define AES_KEY_SIZE 128

// cipher rounds for the chosen key width
`define AES_NUM_ROUNDS \
    ((`AES_KEY_SIZE == 256) ? 14 : \
     (`AES_KEY_SIZE == 192) ? 12 : 10)

// key width in bytes
`define AES_KEY_BYTES (`AES_KEY_SIZE / 8)

`endif

// File: verif/AESEncryptTb.sv
// AES encryptor testbench
// compares the encryptor with a behavioral AES-128 model on fixed and random requests

`include "aes_cfg.svh"

module AESEncryptTb;

    localparam int LATENCY = `AES_NUM_ROUNDS + 1;
    localparam int NUM_RANDOM = 200;
    localparam int TIMEOUT_CYCLES = 16 + (NUM_RANDOM + 1) * 14 + 200;
    localparam AESDefinitions::block_t KNOWN_CT = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

    logic clk = 1'b0;
    logic rst;
    logic start;
    logic busy;
    logic done;
    AESDefinitions::aesReq_t req;
    AESDefinitions::block_t ciphertext;
    AESDefinitions::byte_t refSbox [0:255];
    AESDefinitions::block_t expQ [$];
    int cycleCount = 0;

    AESEncryptTop uut (.*);
    bind AESEncryptTop AESEncryptProperties props (.*);

    always #4 clk = ~clk;

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic checkBlock(input string name, input AESDefinitions::block_t expected,
        input AESDefinitions::block_t actual);
        if (actual !== expected)
            abortRun($sformatf("[FAIL] %s expected 0x%h, got 0x%h", name, expected, actual));
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            abortRun($sformatf("[FAIL] %s expected 0x%h, got 0x%h", name, expected, actual));
    endtask

    // GF(2^8) multiply by shift and add
    function automatic AESDefinitions::byte_t gmul(input AESDefinitions::byte_t a, input int b);
        AESDefinitions::byte_t p;
        p = 8'h00;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                p ^= a;
            a = {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
        end
        return p;
    endfunction

    // S-box as the multiplicative inverse followed by the affine map
    task automatic buildSbox();
        AESDefinitions::byte_t inv;
        for (int b = 0; b < 256; b++)
        begin
            inv = 8'h00;
            for (int c = 1; c < 256; c++)
                if (gmul(8'(b), c) == 8'h01)
                    inv = 8'(c);
            refSbox[b] = inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
                ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
        end
    endtask

    // AES-128 on one block, bytes in column-major order
    function automatic AESDefinitions::block_t aesEncryptRef(input AESDefinitions::aesKey_t key,
        input AESDefinitions::block_t pt);
        AESDefinitions::byte_t rk [0:175];
        AESDefinitions::byte_t rc;
        AESDefinitions::block_t s;
        AESDefinitions::block_t t;
        rc = 8'h01;
        for (int i = 0; i < 16; i++)
            rk[i] = key[i];
        for (int i = 16; i < 176; i++)
        begin
            // first word of each key block gets RotWord, SubWord and Rcon
            if (i % 16 >= 4)
                rk[i] = rk[i-16] ^ rk[i-4];
            else
                rk[i] = rk[i-16] ^ (i % 16 == 0 ? rc : 8'h00)
                    ^ refSbox[rk[i - i % 4 - 4 + (i + 1) % 4]];
            if (i % 16 == 15)
                rc = gmul(rc, 2);
        end
        s = pt;
        for (int i = 0; i < 16; i++)
            s[i] ^= rk[i];
        for (int rnd = 1; rnd <= 10; rnd++)
        begin
            // ShiftRows is folded into the SubBytes read index
            for (int i = 0; i < 16; i++)
                t[i] = refSbox[s[(i + 4 * (i % 4)) % 16]];
            for (int i = 0; i < 16; i++)
            begin
                s[i] = (rnd == 10) ? t[i] : (gmul(t[i], 2) ^ gmul(t[i - i % 4 + (i + 1) % 4], 3)
                    ^ t[i - i % 4 + (i + 2) % 4] ^ t[i - i % 4 + (i + 3) % 4]);
                s[i] ^= rk[16 * rnd + i];
            end
        end
        return s;
    endfunction

    // one request; with poke set, other requests are started while the block is in flight
    task automatic runRequest(input AESDefinitions::aesReq_t r,
        input AESDefinitions::block_t expected, input logic poke);
        int cycles;
        cycles = 0;
        req = r;
        start = 1'b1;
        expQ.push_back(expected);
        @(negedge clk);
        while (!done)
        begin
            checkBit("busy", 1'b1, busy);
            cycles++;
            if (cycles > LATENCY)
                abortRun("done pulse did not arrive in time");
            start = poke && (cycles % 3 == 1);
            req = ~r;
            @(negedge clk);
        end
        start = 1'b0;
        if (cycles != LATENCY)
            abortRun($sformatf("done came %0d cycles after the start, not %0d", cycles, LATENCY));
        checkBit("busy", 1'b0, busy);
    endtask

    // compares each finished block and bounds the run length
    always @(negedge clk)
    begin
        cycleCount++;
        if (cycleCount > TIMEOUT_CYCLES)
            abortRun("the run went past its cycle limit, the DUT looks stuck");
        if (uut.props.failCount != 0)
            abortRun("a protocol assertion on done, busy or ciphertext failed");
        if (!rst && done)
        begin
            if (expQ.size() == 0)
                abortRun("done pulse with no request outstanding");
            else
                checkBlock("ciphertext", expQ.pop_front(), ciphertext);
        end
    end

    initial
    begin
        AESDefinitions::aesReq_t r;
        rst = 1'b1;
        start = 1'b0;
        req = '0;
        void'($urandom(44));
        buildSbox();
        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        checkBit("busy", 1'b0, busy);
        checkBit("done", 1'b0, done);
        checkBlock("ciphertext", '0, ciphertext);
        // FIPS-197 example vector
        r.key = 128'h000102030405060708090a0b0c0d0e0f;
        r.plaintext = 128'h00112233445566778899aabbccddeeff;
        checkBlock("reference", KNOWN_CT, aesEncryptRef(r.key, r.plaintext));
        runRequest(r, KNOWN_CT, 1'b0);
        for (int n = 0; n < NUM_RANDOM; n++)
        begin
            for (int b = 0; b < $bits(r) / 32; b++)
                r[32*b +: 32] = $urandom;
            runRequest(r, aesEncryptRef(r.key, r.plaintext), n >= NUM_RANDOM - 3);
        end
        repeat (30) @(negedge clk);
        if (expQ.size() != 0)
            abortRun("a request finished without its ciphertext being checked");
        else
        begin
            $display("No errors");
            $finish;
        end
    end

endmodule

// File: verif/AESEncrypt_properties.sv
// AES encryptor protocol checks
// bound into the top level to watch the done pulse, the busy level and the ciphertext

module AESEncryptProperties
(
    input logic                   clk,
    input logic                   rst,
    input logic                   busy,
    input logic                   done,
    input AESDefinitions::block_t ciphertext
);

    int failCount = 0;

    // done is a single-cycle pulse
    doneOneCycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else
    begin
        failCount++;
        $error("done stayed high for two cycles in a row");
    end

    // busy drops on exactly the edge that raises done
    busyEndsWithDone: assert property (@(posedge clk) disable iff (rst)
        $rose(done) == $fell(busy))
    else
    begin
        failCount++;
        $error("busy fall and done rise are not on the same edge");
    end

    // the output block only changes when a request completes
    cipherStable: assert property (@(posedge clk) disable iff (rst) busy |-> $stable(ciphertext))
    else
    begin
        failCount++;
        $error("ciphertext changed while busy was high");
    end

endmodule
